// ==== sim.f ====
snd_cfg_pkg.sv
snd_int_pkg.sv
snd_host_regs.sv
snd_timebase.sv
snd_int_ctrl.sv
upd1771c_snd.sv
tb_snd_assert.sv
tb_upd1771c_snd.sv

// ==== Makefile ====
# Verilator build and run for the uPD1771C sound block testbench

VERILATOR ?= verilator
TOP       ?= tb_upd1771c_snd
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_upd1771c_snd.sv ====
// each test starts from its own reset; irq waits are bounded by two time-interrupt periods
module tb_upd1771c_snd
  import snd_cfg_pkg::*, snd_int_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int TIME_CYCLES = 512 * TICK_DIV;             // clocks per time interrupt
  localparam int WATCHDOG    = 60 * TIME_CYCLES * CLK_PERIOD;

  logic    CLK;
  logic    rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    irq;
  vec_t    irq_vec;
  int_id_e irq_id;
  pcm_t    pcm_out;

  integer seed = 32'hf82a;
  int     err_cnt;
  int     test_base;      // error total when the current test began
  int     tests_run;
  int     tests_failed;

  upd1771c_snd uut (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .irq     (irq),
    .irq_vec (irq_vec),
    .irq_id  (irq_id),
    .pcm_out (pcm_out)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////
  // reporting

  function automatic int total_errors();
    return err_cnt + uut.u_assert.fail_cnt;  // includes bound checks
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic check_eq(input string what, input int got, input int exp);
    assert (got == exp)
      else report_mismatch($sformatf("%s is 0x%0h, expected 0x%0h", what, got, exp));
  endtask

  task automatic begin_test();
    test_base = total_errors();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() != test_base) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  ////////////////////
  // bus and timing helpers

  task automatic apply_reset();
    @(negedge CLK);
    rst_n = 1'b0;
    repeat (4) @(negedge CLK);
    rst_n = 1'b1;
  endtask

  // returns on the falling edge inside the ack cycle
  task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                          output wb_dat_t rdat);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge CLK);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge CLK);
    while (!wb_rsp.ack && wait_cnt < 16) begin
      @(negedge CLK);
      wait_cnt++;
    end
    if (!wb_rsp.ack) begin
      report_error($sformatf("no Wishbone ack for address %0d", adr));
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
    wb_dat_t rsp_dat;
    wb_cycle(1'b1, adr, dat, rsp_dat);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
    wb_cycle(1'b0, adr, 8'h00, dat);
  endtask

  task automatic wait_irq(input int limit, output bit seen);
    int cnt;
    cnt = 0;
    while (!irq && cnt < limit) begin
      @(negedge CLK);
      cnt++;
    end
    seen = irq;
  endtask

  task automatic ack_irq();
    wb_write(ADR_INT_ACK, 8'h00);
    @(negedge CLK);  // irq gone by now
  endtask

  // lfsr steps from one value to the other, 0 when not reached within 127
  function automatic int lfsr_steps(input rg_t from, input rg_t to);
    rg_t x;
    int  k;
    int  steps;
    x     = from;
    steps = 0;
    for (k = 1; k <= 127; k++) begin
      x = {x[5:0], ~(x[5] ^ x[6])};
      if (x == to && steps == 0) begin
        steps = k;
      end
    end
    return steps;
  endfunction

  ////////////////////
  // tests

  task automatic test_readback();
    wb_dat_t d;
    wb_dat_t r;
    int      i;
    apply_reset();
    wb_read(ADR_RG, r);
    check_eq("RG after reset", r, 0);
    for (i = 0; i < 8; i++) begin
      d = wb_dat_t'($random(seed));
      wb_write(ADR_N, d);
      wb_read(ADR_N, r);
      check_eq("N readback", r, d);
      wb_write(3'd7, ~d);              // unmapped, must not land anywhere
      wb_read(ADR_N, r);
      check_eq("N after unmapped write", r, d);
      d = wb_dat_t'($random(seed));
      wb_write(ADR_MODE, d);
      wb_read(ADR_MODE, r);
      check_eq("MODE readback", r, d & 8'h1f);
      d = wb_dat_t'($random(seed));
      wb_write(ADR_DA_SIGN, d);
      wb_read(ADR_DA_SIGN, r);
      check_eq("DA_SIGN readback", r, d & 8'h03);
    end
    wb_read(ADR_DA_VAL, r);
    check_eq("DA_VAL read", r, 0);
    wb_read(ADR_INT_ACK, r);
    check_eq("INT_ACK read", r, 0);
    wb_read(3'd7, r);
    check_eq("unmapped read", r, 0);
  endtask

  task automatic test_pcm();
    wb_dat_t    d;
    logic [7:0] mag;
    pcm_t       exp;
    int         s;
    int         i;
    apply_reset();
    for (s = 0; s < 4; s++) begin
      wb_write(ADR_DA_SIGN, wb_dat_t'(s));   // bit 0 ss, bit 1 ts
      for (i = 0; i < 8; i++) begin
        d   = wb_dat_t'($random(seed));
        mag = (s[0] ^ s[1]) ? 8'hff - d : d;
        // negative sample is minus the magnitude minus one
        exp = s[0] ? pcm_t'(-1 - int'(mag)) : pcm_t'(mag);
        wb_write(ADR_DA_VAL, d);
        check_eq($sformatf("pcm_out for 0x%0h, signs %0d", d, s), pcm_out, exp);
      end
    end
  endtask

  task automatic test_time_irq();
    wb_dat_t r;
    bit      seen;
    apply_reset();
    wb_write(ADR_MODE, 8'h04);
    wait_irq(2 * TIME_CYCLES, seen);
    if (!seen) begin
      report_error("time interrupt never raised irq");
    end else begin
      check_eq("time vector", irq_vec, VEC_TIME);
      check_eq("time id", irq_id, INT_TIME);
      wb_read(ADR_STATUS, r);
      check_eq("STATUS", r, 8'h80 | 8'(INT_TIME));
      wb_write(ADR_INT_ACK, 8'h00);
      check_eq("irq in INT_ACK ack cycle", irq, 1);
      @(negedge CLK);
      check_eq("irq one cycle after INT_ACK", irq, 0);
    end
  endtask

  task automatic tone_case(input n_t n, input vec_t exp_vec);
    bit seen;
    apply_reset();
    wb_write(ADR_N, n);
    wb_write(ADR_MODE, 8'h01);
    wait_irq(2 * TIME_CYCLES, seen);
    if (!seen) begin
      report_error($sformatf("no tone interrupt with N = 0x%0h", n));
    end else begin
      check_eq($sformatf("tone vector for N = 0x%0h", n), irq_vec, exp_vec);
      check_eq("tone id", irq_id, INT_TONE);
      ack_irq();
    end
  endtask

  task automatic test_tone_irq();
    bit seen;
    tone_case(8'h30, 12'h028);
    tone_case(8'h48, 12'h02c);
    apply_reset();
    wb_write(ADR_N, 8'h05);          // below the tone range
    wb_write(ADR_MODE, 8'h01);
    wait_irq(2 * TIME_CYCLES, seen);
    assert (!seen)
      else report_error("tone interrupt raised with N = 0x05");
  endtask

  task automatic test_ns_irq();
    wb_dat_t prev;
    wb_dat_t cur;
    bit      have_prev;
    bit      seen;
    int      i;
    apply_reset();
    have_prev = 1'b0;
    prev      = '0;
    wb_write(ADR_MODE, 8'h1a);       // ns_ie, ns_rate 3
    for (i = 0; i < 6; i++) begin
      wait_irq(2 * TIME_CYCLES, seen);
      if (!seen) begin
        report_error("no NS interrupt");
        break;
      end
      check_eq("NS vector", irq_vec, VEC_NS);
      check_eq("NS id", irq_id, INT_NS);
      wb_read(ADR_RG, cur);
      if (have_prev) begin
        assert (cur != prev)
          else report_error("RG did not move between NS interrupts");
        // one ns trigger, so one lfsr step, between acknowledged interrupts
        check_eq("LFSR steps between RG reads", lfsr_steps(prev[6:0], cur[6:0]), 1);
      end
      prev      = cur;
      have_prev = 1'b1;
      ack_irq();
    end
  endtask

  task automatic test_priority();
    vec_t v;
    int   id;
    int   hold;
    int   i;
    int   k;
    bit   seen;
    apply_reset();
    wb_write(ADR_N, 8'h48);
    wb_write(ADR_MODE, 8'h1f);       // every source, fastest noise rate
    for (i = 0; i < 32; i++) begin
      wait_irq(2 * TIME_CYCLES, seen);
      if (!seen) begin
        report_error("irq stopped with all sources enabled");
        break;
      end
      v  = irq_vec;
      id = irq_id;
      assert ((v == 12'h02c && id == INT_TONE) || (v == VEC_NS && id == INT_NS) ||
              (v == VEC_TIME && id == INT_TIME))
        else report_mismatch($sformatf("vector 0x%0h with id %0d outside the set", v, id));
      hold = $random(seed) & 7;
      for (k = 0; k < hold; k++) begin
        @(negedge CLK);
        check_eq("vector held before INT_ACK", irq_vec, v);
      end
      ack_irq();
    end
  endtask

  ////////////////////
  // main sequence

  initial begin
    rst_n        = 1'b0;
    wb_req       = '0;
    err_cnt      = 0;
    test_base    = 0;
    tests_run    = 0;
    tests_failed = 0;

    begin_test();
    test_readback();
    end_test("register readback");
    begin_test();
    test_pcm();
    end_test("pcm conversion");
    begin_test();
    test_time_irq();
    end_test("time interrupt");
    begin_test();
    test_tone_irq();
    end_test("tone interrupt");
    begin_test();
    test_ns_irq();
    end_test("ns interrupt and rg");
    begin_test();
    test_priority();
    end_test("priority");

    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // hang guard, far beyond the longest test
  initial begin
    #(WATCHDOG);
    $display("Error at %0t: watchdog expired, a test did not finish", $time);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tb_snd_assert.sv ====
// port level checks only; a failed property bumps fail_cnt next to its $error
module snd_assert
  import snd_cfg_pkg::*, snd_int_pkg::*;
(
  input logic    CLK,
  input logic    rst_n,
  input wb_req_t wb_req,
  input wb_rsp_t wb_rsp,
  input logic    irq,
  input vec_t    irq_vec,
  input int_id_e irq_id,
  input pcm_t    pcm_out
);

  int fail_cnt = 0;

  ////////////////////
  // wishbone handshake

  ack_follows_req: assert property (@(posedge CLK) disable iff (!rst_n)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else begin
      $error("ack without cyc and stb in the cycle before");
      fail_cnt++;
    end

  ack_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      $error("ack held longer than one cycle");
      fail_cnt++;
    end

  ////////////////////
  // interrupt and reset

  irq_fields_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    (irq && $past(irq)) |-> ($stable(irq_vec) && $stable(irq_id)))
    else begin
      $error("irq_vec or irq_id changed while irq was high");
      fail_cnt++;
    end

  idle_after_reset: assert property (@(posedge CLK)
    !$past(rst_n) |-> (!wb_rsp.ack && !irq && pcm_out == '0))  // sync reset, one edge
    else begin
      $error("outputs not idle after reset");
      fail_cnt++;
    end

endmodule

bind upd1771c_snd snd_assert u_assert (
  .CLK     (CLK),
  .rst_n   (rst_n),
  .wb_req  (wb_req),
  .wb_rsp  (wb_rsp),
  .irq     (irq),
  .irq_vec (irq_vec),
  .irq_id  (irq_id),
  .pcm_out (pcm_out)
);

// ==== upd1771c_snd.sv ====
// sound timing block of the uPD1771C behind a wishbone port; no cpu, noise sign fixed at zero
module upd1771c_snd
  import snd_cfg_pkg::*, snd_int_pkg::*;
(
  input  logic    CLK,
  input  logic    rst_n,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp,
  output logic    irq,
  output vec_t    irq_vec,
  output int_id_e irq_id,
  output pcm_t    pcm_out
);

  n_t          n;
  snd_mode_t   mode;
  logic        int_ack;
  rg_t         rg;
  snd_trig_t   trig;
  int_status_t int_status;

  ////////////////////
  // host registers

  snd_host_regs u_host_regs (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .rg         (rg),
    .int_status (int_status),
    .n          (n),
    .mode       (mode),
    .int_ack    (int_ack),
    .pcm        (pcm_out)
  );

  snd_timebase u_timebase (
    .CLK   (CLK),
    .rst_n (rst_n),
    .n     (n),
    .mode  (mode),
    .trig  (trig),
    .rg    (rg)
  );

  snd_int_ctrl u_int_ctrl (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .trig    (trig),
    .int_ack (int_ack),
    .status  (int_status)
  );

  assign irq     = int_status.active;
  assign irq_vec = int_status.vec;
  assign irq_id  = int_status.id;

endmodule

// ==== snd_int_ctrl.sv ====
// one interrupt active at a time; a repeat trigger while pending is merged into one request
module snd_int_ctrl
  import snd_int_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  snd_trig_t   trig,
  input  logic        int_ack,
  output int_status_t status
);

  int_state_e state;
  logic [2:0] pending;       // indexed by int_id_e
  logic [2:0] set_pend;
  logic [2:0] clr_pend;
  logic [1:0] tone_range_q;  // range at the time tone went pending
  logic       grant;
  int_id_e    sel_id;
  vec_t       sel_vec;

  always_comb begin
    set_pend           = '0;
    set_pend[INT_TONE] = trig.tone;
    set_pend[INT_NS]   = trig.ns;
    set_pend[INT_TIME] = trig.timer;
  end

  ////////////////////
  // priority pick

  always_comb begin
    if (pending[INT_TONE]) begin
      sel_id = INT_TONE;
    end else if (pending[INT_NS]) begin
      sel_id = INT_NS;
    end else begin
      sel_id = INT_TIME;
    end
  end

  always_comb begin
    case (sel_id)
      INT_TONE: sel_vec = VEC_TONE_BASE + vec_t'(tone_range_q) * VEC_RANGE_STEP;
      INT_NS:   sel_vec = VEC_NS;
      default:  sel_vec = VEC_TIME;
    endcase
  end

  assign grant    = (state == INT_IDLE) & (|pending);
  assign clr_pend = grant ? (3'b001 << sel_id) : 3'b000;

  ////////////////////
  // state and status

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state        <= INT_IDLE;
      pending      <= '0;
      tone_range_q <= '0;
      status       <= '0;
    end else begin
      pending <= (pending & ~clr_pend) | set_pend;  // new trigger wins
      if (trig.tone) begin
        tone_range_q <= trig.tone_range;
      end
      case (state)
        INT_IDLE: begin
          if (grant) begin
            state         <= INT_BUSY;
            status.active <= 1'b1;
            status.id     <= sel_id;   // held until ack
            status.vec    <= sel_vec;
          end
        end
        INT_BUSY: begin
          if (int_ack) begin
            state         <= INT_IDLE;
            status.active <= 1'b0;
          end
        end
        default: state <= INT_IDLE;
      endcase
    end
  end

endmodule

// ==== snd_timebase.sv ====
// tick prescaler, tone/time counters and lfsr; N may change at any time, range follows it at once
module snd_timebase
  import snd_cfg_pkg::*, snd_int_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  n_t        n,
  input  snd_mode_t mode,
  output snd_trig_t trig,
  output rg_t       rg
);

  logic [$clog2(TICK_DIV)-1:0] pre_cnt;
  logic       tick;
  n_t         nc;            // tone down-counter
  logic       nc_reload;
  logic       nc_reload_d;   // reload seen on the previous tick
  logic [2:0] nuc;           // reload counter
  tc_t        tc;            // time up-counter
  logic [1:0] tone_range;
  logic       tone_cond;
  logic       tone_cond_d;
  logic       time_d;
  logic       ns_sel;
  logic       ns_sel_d;
  logic       tone_edge;
  logic       time_edge;
  logic       ns_edge;

  ////////////////////
  // prescaler

  assign tick = (pre_cnt == TICK_DIV - 1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pre_cnt <= '0;
    end else if (tick) begin
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  ////////////////////
  // counters

  assign nc_reload = (nc == 8'd1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      nc          <= '0;
      nc_reload_d <= 1'b0;
      nuc         <= '0;
      tc          <= '0;
    end else if (tick) begin
      nc          <= nc_reload ? n : nc - 1'b1;
      nc_reload_d <= nc_reload;
      if (nc_reload_d) begin
        nuc <= nuc + 1'b1;  // one tick after the reload
      end
      tc <= tc + 1'b1;      // free running, wraps every 512 ticks
    end
  end

  ////////////////////
  // tone condition

  // higher N ranges tap a faster reload counter bit
  always_comb begin
    if (n < 8'h08) begin
      tone_range = 2'd0;
      tone_cond  = 1'b0;        // too short, no tone
    end else if (n < 8'h10) begin
      tone_range = 2'd0;
      tone_cond  = nuc[2];
    end else if (n < 8'h20) begin
      tone_range = 2'd1;
      tone_cond  = nuc[1];
    end else if (n < 8'h40) begin
      tone_range = 2'd2;
      tone_cond  = nuc[0];
    end else begin
      tone_range = 2'd3;
      tone_cond  = nc_reload_d;
    end
  end

  // noise rate tap
  always_comb begin
    case (mode.ns_rate)
      2'd0:    ns_sel = tc[8];
      2'd1:    ns_sel = tc[7];
      2'd2:    ns_sel = tc[5];
      default: ns_sel = tc[4];
    endcase
  end

  ////////////////////
  // falling edges

  assign tone_edge = tick & tone_cond_d & ~tone_cond;
  assign time_edge = tick & time_d & ~tc[8];
  assign ns_edge   = tick & ns_sel_d & ~ns_sel;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tone_cond_d <= 1'b0;
      time_d      <= 1'b0;
      ns_sel_d    <= 1'b0;
      trig        <= '0;
      rg          <= '0;
    end else begin
      if (tick) begin
        tone_cond_d <= tone_cond;
        time_d      <= tc[8];
        ns_sel_d    <= ns_sel;
      end
      trig.tone       <= tone_edge & mode.tone_ie;
      trig.ns         <= ns_edge & mode.ns_ie;
      trig.timer      <= time_edge & mode.time_ie;
      trig.tone_range <= tone_range;
      // lfsr steps on every ns edge, enabled or not
      if (ns_edge) begin
        rg <= {rg[5:0], ~(rg[5] ^ rg[6])};
      end
    end
  end

endmodule

// ==== snd_host_regs.sv ====
// wishbone classic slave, zero wait state; read data is only valid in the ack cycle
module snd_host_regs
  import snd_cfg_pkg::*, snd_int_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  wb_req_t     wb_req,
  output wb_rsp_t     wb_rsp,
  input  rg_t         rg,
  input  int_status_t int_status,
  output n_t          n,
  output snd_mode_t   mode,
  output logic        int_ack,
  output pcm_t        pcm
);

  logic    acc;        // new access seen this cycle
  logic    wr_acc;
  logic    rd_acc;
  logic    ack_q;
  wb_dat_t rd_mux;
  wb_dat_t rd_dat;
  logic    ss;         // sample sign
  logic    ts;         // tone sign
  logic [7:0] da_mag;
  pcm_t    pcm_nxt;

  // ack drops for one cycle between back to back accesses
  assign acc    = wb_req.cyc & wb_req.stb & ~ack_q;
  assign wr_acc = acc & wb_req.we;
  assign rd_acc = acc & ~wb_req.we;

  ////////////////////
  // read mux

  always_comb begin
    case (wb_req.adr)
      ADR_N:       rd_mux = n;
      ADR_MODE:    rd_mux = {3'b000, mode};
      ADR_DA_SIGN: rd_mux = {6'b000000, ts, ss};
      ADR_RG:      rd_mux = {1'b0, rg};
      ADR_STATUS:  rd_mux = {int_status.active, 5'b00000, int_status.id};
      default:     rd_mux = '0;  // unmapped and write-only
    endcase
  end

  ////////////////////
  // dac sample

  // magnitude flips when the two signs disagree
  always_comb begin
    da_mag = (ss ^ ts) ? ~wb_req.dat : wb_req.dat;
    if (ss) begin
      pcm_nxt = {1'b1, ~da_mag};  // negative half
    end else begin
      pcm_nxt = {1'b0, da_mag};
    end
  end

  ////////////////////
  // register file

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ack_q   <= 1'b0;
      int_ack <= 1'b0;
      n       <= '0;
      mode    <= '0;
      ss      <= 1'b0;
      ts      <= 1'b0;
      pcm     <= '0;
    end else begin
      ack_q   <= acc;
      int_ack <= wr_acc & (wb_req.adr == ADR_INT_ACK);  // one cycle, with ack
      if (wr_acc) begin
        case (wb_req.adr)
          ADR_N:       n <= wb_req.dat;
          ADR_MODE:    mode <= snd_mode_t'(wb_req.dat[4:0]);
          ADR_DA_SIGN: begin
            ss <= wb_req.dat[0];
            ts <= wb_req.dat[1];
          end
          ADR_DA_VAL:  pcm <= pcm_nxt;  // shows on pcm_out with ack
          default: ;
        endcase
      end
    end
  end

  // zero outside a read ack
  always_ff @(posedge CLK) begin
    rd_dat <= rd_acc ? rd_mux : '0;
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_dat;

endmodule

// ==== snd_int_pkg.sv ====
// interrupt ids, vectors and status types; three sources only, priority fixed by enum order
package snd_int_pkg;

  ////////////////////
  // sources and vectors

  // lower value wins, tone first
  typedef enum logic [1:0] {
    INT_TONE = 2'd0,
    INT_NS   = 2'd1,
    INT_TIME = 2'd2
  } int_id_e;

  typedef logic [11:0] vec_t;

  localparam vec_t VEC_TONE_BASE  = 12'h020;
  localparam vec_t VEC_NS         = 12'h048;
  localparam vec_t VEC_TIME       = 12'h080;
  localparam vec_t VEC_RANGE_STEP = 12'h004;  // per tone range step

  ////////////////////
  // stage interfaces

  // single clock pulses, already gated by the mode enables
  typedef struct packed {
    logic       tone;
    logic       ns;
    logic       timer;
    logic [1:0] tone_range;  // range of N, picks the tone vector
  } snd_trig_t;

  typedef struct packed {
    logic    active;
    int_id_e id;
    vec_t    vec;
  } int_status_t;

  typedef enum logic {
    INT_IDLE = 1'b0,
    INT_BUSY = 1'b1
  } int_state_e;

endpackage

// ==== snd_cfg_pkg.sv ====
// register map, widths and bus types; counter tick fixed at one per TICK_DIV clocks, no runtime change
package snd_cfg_pkg;

  ////////////////////
  // bus and value widths

  typedef logic [2:0] wb_adr_t;   // word address
  typedef logic [7:0] wb_dat_t;   // bus data

  typedef logic [7:0] n_t;        // tone reload value
  typedef logic [8:0] tc_t;       // time up-counter
  typedef logic [6:0] rg_t;       // lfsr value
  typedef logic [8:0] pcm_t;      // two's complement sample

  ////////////////////
  // timing

  // clocks per counter tick, one machine cycle of the original part
  localparam int TICK_DIV = 8;

  ////////////////////
  // register map

  localparam wb_adr_t ADR_N       = 3'd0;
  localparam wb_adr_t ADR_MODE    = 3'd1;
  localparam wb_adr_t ADR_DA_VAL  = 3'd2;  // write only
  localparam wb_adr_t ADR_DA_SIGN = 3'd3;
  localparam wb_adr_t ADR_INT_ACK = 3'd4;  // write only, data ignored
  localparam wb_adr_t ADR_RG      = 3'd5;  // read only
  localparam wb_adr_t ADR_STATUS  = 3'd6;  // read only

  // wishbone classic request, master side
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

  // field order matches the MODE register bits 4:0
  typedef struct packed {
    logic [1:0] ns_rate;  // 0..3 selects tc bit 8, 7, 5, 4
    logic       time_ie;
    logic       ns_ie;
    logic       tone_ie;
  } snd_mode_t;

endpackage
